// File: all.f
+incdir+source
source/matcher_pkg.sv
source/stream_context_ram.sv
source/signature_dfa.sv
source/match_tally.sv
source/packet_sequencer.sv
source/signature_matcher_top.sv
verification/signature_matcher_tb.sv

// File: source/match_tally.sv
module match_tally
   import matcher_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n,
   input  logic         ctx_load,
   input  logic         ctx_fresh,
   input  match_count_t stream_total_in,
   input  logic         accept,
   input  logic         commit,
   input  logic         discard,
   output logic         fired,
   output match_count_t count,
   output match_count_t stream_total,
   output logic         stream_total_vld
);

   match_count_t total_q;
   logic         hit;

   // Accept can land in the eop cycle itself, before fired is set
   assign hit = fired | accept;

   // Restored total plus this packet's match
   // Also the write data of the total memory at commit
   assign stream_total = total_q + match_count_t'(hit);

   // Latch restored per-stream total, zero for a new stream
   always_ff @(posedge clk)
   begin
      if (ctx_load)
      begin
         total_q <= ctx_fresh ? match_count_t'(0) : stream_total_in;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         fired            <= 1'b0;
         count            <= '0;
         stream_total_vld <= 1'b0;
      end
      else
      begin
         stream_total_vld <= commit;
         // Speculative flag, several matches in a packet count once
         if (accept)
            fired <= 1'b1;
         // New packet or disabled stream drops the flag
         if (ctx_load || discard)
            fired <= 1'b0;
         if (commit)
            count <= count + match_count_t'(hit);
      end
   end

endmodule

// File: source/matcher_params.svh
`ifndef MATCHER_PARAMS_SVH
`define MATCHER_PARAMS_SVH

// Number of interleaved stream contexts
`define MATCHER_STREAMS 64

// Literal to find, first byte in the top position
`define MATCHER_PATTERN 32'h47455420

// Bytes in the literal
`define MATCHER_PATTERN_LEN 4

// Width of the global count and per-stream totals
`define MATCHER_COUNT_W 16

`endif

// File: source/matcher_pkg.sv
`include "matcher_params.svh"

package matcher_pkg;

   // Stream number, one entry per context
   typedef logic [$clog2(`MATCHER_STREAMS)-1:0] stream_id_t;

   // Pattern bytes matched so far, 0 up to the pattern length
   typedef logic [$clog2(`MATCHER_PATTERN_LEN+1)-1:0] dfa_state_t;

   // Global match count and per-stream totals
   typedef logic [`MATCHER_COUNT_W-1:0] match_count_t;

   // Packet sequencer phases
   typedef enum logic [1:0]
   {
      IDLE,
      RESTORE,
      RUN
   } seq_phase_t;

endpackage

// File: source/packet_sequencer.sv
module packet_sequencer
   import matcher_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       load_state,
   input  logic       new_stream_id,
   input  logic       enable,
   input  logic       eop,
   input  stream_id_t stream_id,
   // Context memory control
   output logic       ctx_rd,
   output logic       ctx_load,
   output logic       ctx_fresh,
   output logic       ctx_wr,
   output stream_id_t ctx_addr,
   // End of packet decision
   output logic       commit,
   output logic       discard
);

   seq_phase_t phase;
   seq_phase_t phase_nxt;
   stream_id_t stream_q;
   logic       fresh_q;
   logic       enable_q;

   // Phase transitions
   always_comb
   begin
      phase_nxt = phase;
      unique case (phase)
         IDLE:
         begin
            if (load_state)
               phase_nxt = RESTORE;
         end
         // Read data valid this cycle, one cycle is enough
         RESTORE:
            phase_nxt = RUN;
         RUN:
         begin
            if (eop)
               phase_nxt = IDLE;
         end
         default:
            phase_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         phase <= IDLE;
      else
         phase <= phase_nxt;
   end

   // Packet attributes held until eop
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         stream_q <= '0;
         fresh_q  <= 1'b0;
         enable_q <= 1'b0;
      end
      else if (phase == IDLE && load_state)
      begin
         stream_q <= stream_id;
         fresh_q  <= new_stream_id;
         enable_q <= enable;
      end
   end

   // Read issued with load_state so data is ready in RESTORE
   assign ctx_rd   = (phase == IDLE) && load_state;
   // Live stream id for the read, latched one for write-back
   assign ctx_addr = (phase == IDLE) ? stream_id : stream_q;

   // DFA and tally take the context in RESTORE
   assign ctx_load  = (phase == RESTORE);
   assign ctx_fresh = fresh_q;

   // Enabled stream keeps its result, disabled one drops it
   assign commit  = (phase == RUN) && eop && enable_q;
   assign discard = (phase == RUN) && eop && !enable_q;
   assign ctx_wr  = commit;

   // Stimulus must frame packets cleanly
   a_eop_only_in_run : assert property (
      @(posedge clk) disable iff (!rst_n) eop |-> (phase == RUN)
   );

   a_no_load_in_run : assert property (
      @(posedge clk) disable iff (!rst_n) load_state |-> (phase != RUN)
   );

endmodule

// File: source/signature_dfa.sv
`include "matcher_params.svh"

module signature_dfa
   import matcher_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic [7:0] char_in,
   input  logic       char_in_vld,
   // Context restore at start of packet
   input  logic       ctx_load,
   input  logic       ctx_fresh,
   input  dfa_state_t ctx_state,
   output dfa_state_t cur_state,
   output logic       accept
);

   localparam logic [8*`MATCHER_PATTERN_LEN-1:0] PATTERN = `MATCHER_PATTERN;
   localparam int PAT_LEN = `MATCHER_PATTERN_LEN;
   localparam dfa_state_t FULL = dfa_state_t'(PAT_LEN);

   dfa_state_t state_q;
   dfa_state_t next_match;
   logic [7:0] exp_byte;
   logic [7:0] first_byte;

   // First literal byte, used for the fallback edge
   assign first_byte = PATTERN[8*PAT_LEN-1 -: 8];

   // Byte the DFA expects next for the current prefix
   always_comb
   begin
      exp_byte = first_byte;
      for (int i = 0; i < PAT_LEN; i++)
      begin
         if (state_q == dfa_state_t'(i))
         begin
            exp_byte = PATTERN[8*(PAT_LEN-1-i) +: 8];
         end
      end
   end

   // Advance on a hit, else fall back
   // Fallback to 1 or 0 holds only for a literal without self-overlap
   always_comb
   begin
      if (char_in == exp_byte)
         next_match = state_q + 1'b1;
      else if (char_in == first_byte)
         next_match = dfa_state_t'(1);
      else
         next_match = '0;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_q <= '0;
         accept  <= 1'b0;
      end
      else
      begin
         // Accept lasts a single cycle
         accept <= 1'b0;
         if (ctx_load)
         begin
            state_q <= ctx_fresh ? dfa_state_t'(0) : ctx_state;
         end
         else if (char_in_vld)
         begin
            if (next_match == FULL)
            begin
               // Full literal seen, wrap so back-to-back copies count
               state_q <= '0;
               accept  <= 1'b1;
            end
            else
            begin
               state_q <= next_match;
            end
         end
      end
   end

   // State saved to the context memory at end of packet
   assign cur_state = state_q;

   // Restored contexts and live updates stay inside the prefix range
   a_state_in_range : assert property (
      @(posedge clk) disable iff (!rst_n) state_q <= FULL
   );

endmodule

// File: source/signature_matcher_top.sv
`include "matcher_params.svh"

module signature_matcher_top
   import matcher_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n,
   input  logic         load_state,
   input  logic         new_stream_id,
   input  logic         enable,
   input  logic         eop,
   input  logic [7:0]   char_in,
   input  logic         char_in_vld,
   input  stream_id_t   stream_id,
   output logic         fired,
   output match_count_t count,
   output match_count_t stream_total,
   output logic         stream_total_vld
);

   logic         ctx_rd;
   logic         ctx_load;
   logic         ctx_fresh;
   logic         ctx_wr;
   logic         commit;
   logic         discard;
   logic         accept;
   stream_id_t   ctx_addr;
   dfa_state_t   saved_state;
   dfa_state_t   cur_state;
   match_count_t saved_total;

   // Control
   packet_sequencer u_seq (
      .clk           (clk),
      .rst_n         (rst_n),
      .load_state    (load_state),
      .new_stream_id (new_stream_id),
      .enable        (enable),
      .eop           (eop),
      .stream_id     (stream_id),
      .ctx_rd        (ctx_rd),
      .ctx_load      (ctx_load),
      .ctx_fresh     (ctx_fresh),
      .ctx_wr        (ctx_wr),
      .ctx_addr      (ctx_addr),
      .commit        (commit),
      .discard       (discard)
   );

   // Saved DFA state per stream
   stream_context_ram #(
      .payload_t (dfa_state_t),
      .depth     (`MATCHER_STREAMS)
   ) u_state_ram (
      .clk     (clk),
      .rd      (ctx_rd),
      .rd_addr (ctx_addr),
      .rd_data (saved_state),
      .wr      (ctx_wr),
      .wr_addr (ctx_addr),
      .wr_data (cur_state)
   );

   // Committed match total per stream
   stream_context_ram #(
      .payload_t (match_count_t),
      .depth     (`MATCHER_STREAMS)
   ) u_total_ram (
      .clk     (clk),
      .rd      (ctx_rd),
      .rd_addr (ctx_addr),
      .rd_data (saved_total),
      .wr      (ctx_wr),
      .wr_addr (ctx_addr),
      .wr_data (stream_total)
   );

   signature_dfa u_dfa (
      .clk         (clk),
      .rst_n       (rst_n),
      .char_in     (char_in),
      .char_in_vld (char_in_vld),
      .ctx_load    (ctx_load),
      .ctx_fresh   (ctx_fresh),
      .ctx_state   (saved_state),
      .cur_state   (cur_state),
      .accept      (accept)
   );

   match_tally u_tally (
      .clk              (clk),
      .rst_n            (rst_n),
      .ctx_load         (ctx_load),
      .ctx_fresh        (ctx_fresh),
      .stream_total_in  (saved_total),
      .accept           (accept),
      .commit           (commit),
      .discard          (discard),
      .fired            (fired),
      .count            (count),
      .stream_total     (stream_total),
      .stream_total_vld (stream_total_vld)
   );

endmodule

// File: source/stream_context_ram.sv
module stream_context_ram
   import matcher_pkg::*;
#(
   parameter type payload_t = logic,
   parameter int  depth     = 64
)
(
   input  logic       clk,
   // Read port, data valid the cycle after rd
   input  logic       rd,
   input  stream_id_t rd_addr,
   output payload_t   rd_data,
   // Write port
   input  logic       wr,
   input  stream_id_t wr_addr,
   input  payload_t   wr_data
);

   // One saved context per stream
   payload_t mem [depth];

   // Write side
   always_ff @(posedge clk)
   begin
      if (wr)
      begin
         mem[wr_addr] <= wr_data;
      end
   end

   // Registered read, holds last value when idle
   always_ff @(posedge clk)
   begin
      if (rd)
      begin
         rd_data <= mem[rd_addr];
      end
   end

   // Restore and write-back of one stream never overlap,
   // the sequencer reads only in IDLE and writes only in RUN
   a_no_rd_wr_collision : assert property (
      @(posedge clk) !(rd && wr && (rd_addr == wr_addr))
   );

endmodule

// File: verification/signature_matcher_tb.sv
`include "matcher_params.svh"

module signature_matcher_tb
   import matcher_pkg::*;
;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int clk_period   = 20;
   localparam int reset_cycles = 10;
   // Longest payload and fixed cycles around each packet
   localparam int num_packets  = 39;
   localparam int max_bytes    = 12;
   localparam int pkt_overhead = 8;
   localparam int limit_cycles = reset_cycles + num_packets * (max_bytes + pkt_overhead);

   logic         clk;
   logic         rst_n;
   logic         load_state;
   logic         new_stream_id;
   logic         enable;
   logic         eop;
   logic [7:0]   char_in;
   logic         char_in_vld;
   stream_id_t   stream_id;
   logic         fired;
   match_count_t count;
   match_count_t stream_total;
   logic         stream_total_vld;

   // Reference model of saved contexts
   int ref_state [`MATCHER_STREAMS];
   int ref_total [`MATCHER_STREAMS];
   int ref_count;

   logic [7:0] pkt_data [$];
   int         errors;
   int         checks;
   int         tests;
   int         seed;

   signature_matcher_top uut (
      .clk              (clk),
      .rst_n            (rst_n),
      .load_state       (load_state),
      .new_stream_id    (new_stream_id),
      .enable           (enable),
      .eop              (eop),
      .char_in          (char_in),
      .char_in_vld      (char_in_vld),
      .stream_id        (stream_id),
      .fired            (fired),
      .count            (count),
      .stream_total     (stream_total),
      .stream_total_vld (stream_total_vld)
   );

   initial
   begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   // Watchdog at twice the expected run length
   initial
   begin
      #(limit_cycles * clk_period * 2);
      $display("Timeout: the tests did not complete within %0d cycles", limit_cycles * 2);
      $display("Finished with errors");
      $finish;
   end

   task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("** Error at %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
      end
   endtask

   // Literal byte at a given prefix position
   function automatic logic [7:0] pattern_byte(input int idx);
      logic [8*`MATCHER_PATTERN_LEN-1:0] pat;
      pat = `MATCHER_PATTERN;
      return pat[8*(`MATCHER_PATTERN_LEN-1-idx) +: 8];
   endfunction

   task automatic load_text(input string s);
      pkt_data.delete();
      for (int i = 0; i < s.len(); i++)
         pkt_data.push_back(s[i]);
   endtask

   // Drive one packet from pkt_data, update the model and check the commit
   task automatic send_packet(input int s, input logic fresh, input logic en, input int gap,
                              output logic fired_eop, output logic fired_post);
      int   st;
      logic hit;
      st  = fresh ? 0 : ref_state[s];
      hit = 1'b0;
      // Expected DFA walk with fallback to 1 or 0
      for (int i = 0; i < pkt_data.size(); i++)
      begin
         if (pkt_data[i] == pattern_byte(st))
            st = st + 1;
         else if (pkt_data[i] == pattern_byte(0))
            st = 1;
         else
            st = 0;
         if (st == `MATCHER_PATTERN_LEN)
         begin
            hit = 1'b1;
            st  = 0;
         end
      end
      @(posedge clk);
      load_state    <= 1'b1;
      stream_id     <= stream_id_t'(s);
      new_stream_id <= fresh;
      enable        <= en;
      @(posedge clk);
      load_state    <= 1'b0;
      new_stream_id <= 1'b0;
      enable        <= 1'b0;
      // One idle cycle for the restore before the bytes
      for (int i = 0; i < pkt_data.size(); i++)
      begin
         @(posedge clk);
         char_in     <= pkt_data[i];
         char_in_vld <= 1'b1;
      end
      @(posedge clk);
      char_in_vld <= 1'b0;
      repeat (gap) @(posedge clk);
      eop <= 1'b1;
      @(negedge clk);
      fired_eop = fired;
      check_equal(stream_total_vld, 1'b0, "stream_total_vld during eop");
      @(posedge clk);
      eop <= 1'b0;
      // Commit results are visible one cycle after eop
      @(negedge clk);
      fired_post = fired;
      if (en)
      begin
         ref_total[s] = (fresh ? 0 : ref_total[s]) + hit;
         ref_state[s] = st;
         ref_count    = ref_count + hit;
      end
      check_equal(stream_total_vld, en, "stream_total_vld after eop");
      check_equal(fired, hit && en, "fired after eop");
      check_equal(count, ref_count, "global count");
      if (en)
         check_equal(stream_total, ref_total[s], "stream_total");
   endtask

   task automatic report_test(input string name, input int errs_before);
      tests++;
      if (errors == errs_before)
         $display("%s: pass", name);
      else
         $display("%s: %0d mismatches", name, errors - errs_before);
   endtask

   task automatic test_new_stream_match();
      int   e0;
      int   c0;
      logic fe;
      logic fp;
      e0 = errors;
      c0 = ref_count;
      load_text("GET ");
      // Idle cycle before eop lets fired rise in time
      send_packet(3, 1'b1, 1'b1, 1, fe, fp);
      check_equal(fe, 1'b1, "fired at eop");
      check_equal(count, c0 + 1, "count after first match");
      check_equal(stream_total, 1, "total of new stream");
      report_test("new stream match", e0);
   endtask

   task automatic test_split_match();
      int   e0;
      logic fe;
      logic fp;
      e0 = errors;
      load_text("xGE");
      send_packet(1, 1'b1, 1'b1, 0, fe, fp);
      check_equal(fp, 1'b0, "partial packet fired");
      // Other stream in between
      load_text("abGET ");
      send_packet(2, 1'b1, 1'b1, 0, fe, fp);
      load_text("T ");
      send_packet(1, 1'b0, 1'b1, 0, fe, fp);
      check_equal(fp, 1'b1, "split match fired");
      check_equal(stream_total, 1, "split match total");
      report_test("split match", e0);
   endtask

   task automatic test_disabled_stream();
      int   e0;
      int   c0;
      logic fe;
      logic fp;
      e0 = errors;
      load_text("ab");
      send_packet(5, 1'b1, 1'b1, 0, fe, fp);
      c0 = ref_count;
      load_text("xGET GE");
      send_packet(5, 1'b0, 1'b0, 1, fe, fp);
      // Speculative flag rises and is then dropped
      check_equal(fe, 1'b1, "speculative fired");
      check_equal(count, c0, "count on disabled stream");
      load_text("T ");
      send_packet(5, 1'b0, 1'b1, 0, fe, fp);
      check_equal(fp, 1'b0, "state leaked from disabled packet");
      check_equal(stream_total, 0, "total after disabled packet");
      report_test("disabled stream", e0);
   endtask

   task automatic test_stream_restart();
      int   e0;
      logic fe;
      logic fp;
      e0 = errors;
      load_text("GET GE");
      send_packet(9, 1'b1, 1'b1, 0, fe, fp);
      check_equal(stream_total, 1, "total before restart");
      load_text("T ");
      send_packet(9, 1'b1, 1'b1, 0, fe, fp);
      check_equal(fp, 1'b0, "restarted stream fired");
      check_equal(stream_total, 0, "total after restart");
      load_text("GET ");
      send_packet(9, 1'b0, 1'b1, 0, fe, fp);
      check_equal(stream_total, 1, "total counts from zero");
      report_test("stream restart", e0);
   endtask

   task automatic test_random_payloads();
      int    e0;
      int    len;
      int    s;
      logic  en;
      int    c0;
      logic  fe;
      logic  fp;
      string alphabet;
      e0       = errors;
      alphabet = "GET x";
      // Fresh start of each stream
      for (int k = 0; k < 4; k++)
      begin
         load_text("xx");
         send_packet(20 + k, 1'b1, 1'b1, 0, fe, fp);
      end
      for (int p = 0; p < 24; p++)
      begin
         s   = 20 + $unsigned($random(seed)) % 4;
         en  = ($unsigned($random(seed)) % 4) != 0;
         len = 1 + $unsigned($random(seed)) % max_bytes;
         pkt_data.delete();
         for (int i = 0; i < len; i++)
            pkt_data.push_back(alphabet[$unsigned($random(seed)) % 5]);
         send_packet(s, 1'b0, en, $unsigned($random(seed)) % 2, fe, fp);
      end
      // Two matches in one packet count once
      c0 = ref_count;
      load_text("GET GET ");
      send_packet(21, 1'b1, 1'b1, 0, fe, fp);
      check_equal(count, c0 + 1, "double match count");
      report_test("random payloads", e0);
   endtask

   initial
   begin
      errors    = 0;
      checks    = 0;
      tests     = 0;
      ref_count = 0;
      seed      = 11779;
      rst_n         <= 1'b0;
      load_state    <= 1'b0;
      new_stream_id <= 1'b0;
      enable        <= 1'b0;
      eop           <= 1'b0;
      char_in       <= 8'h00;
      char_in_vld   <= 1'b0;
      stream_id     <= '0;
      repeat (reset_cycles) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_equal(count, 0, "count after reset");
      check_equal(fired, 1'b0, "fired after reset");
      test_new_stream_match();
      test_split_match();
      test_disabled_stream();
      test_stream_restart();
      test_random_payloads();
      $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
      if (errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule
